//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Controller states
    typedef enum logic [2:0] {
        idle,       // Waiting for a request
        cmp_rd,     // Tag compare for a read
        cmp_wr,     // Tag compare for a write
        mem_wb,     // Dirty line going back to memory
        mem_rd,     // Line fill from memory
        cache_wr    // Word write into the freshly filled line
    } ctrl_state_t;

    // Line operations toward the backing memory
    typedef enum logic [1:0] {
        op_none  = 2'b00,
        op_read  = 2'b01,
        op_write = 2'b11
    } mem_op_t;

endpackage

`default_nettype wire

//--- logic/cache_tag_store.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tag_store #(
    parameter int ADDR_WIDTH = 16,
    parameter int WORD_WIDTH = 32,
    parameter int LINE_WORDS = 4,
    parameter int INDEX_BITS = 4,
    localparam int OFFSET_BITS = $clog2(WORD_WIDTH / 8) + $clog2(LINE_WORDS),
    localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS,
    localparam int SETS        = 1 << INDEX_BITS
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [INDEX_BITS-1:0] index,
    input  logic [TAG_BITS-1:0]   tag,
    input  logic                  word_we,
    input  logic                  fill_we,
    output logic                  tag_hit,
    output logic                  tag_valid,
    output logic                  tag_dirty,
    output logic [TAG_BITS-1:0]   old_tag
);

    logic [SETS-1:0]     valid;
    logic [SETS-1:0]     dirty;
    logic [TAG_BITS-1:0] tags [SETS];

    // Status bits per set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (fill_we) begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;   // Fresh line matches memory
        end else if (word_we) begin
            dirty[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we)
            tags[index] <= tag;
    end

    assign tag_valid = valid[index];
    assign tag_dirty = dirty[index];
    assign old_tag   = tags[index];    // Also the write-back address
    assign tag_hit   = tag_valid && (old_tag == tag);

endmodule

`default_nettype wire

//--- logic/cache_line_store.sv
`timescale 1ns/1ns
`default_nettype none

module cache_line_store #(
    parameter int WORD_WIDTH = 32,
    parameter int LINE_WORDS = 4,
    parameter int INDEX_BITS = 4,
    localparam int SEL_BITS   = $clog2(LINE_WORDS),
    localparam int LINE_WIDTH = LINE_WORDS * WORD_WIDTH,
    localparam int SETS       = 1 << INDEX_BITS
) (
    input  logic                  clk,
    input  logic [INDEX_BITS-1:0] index,
    input  logic [SEL_BITS-1:0]   word_sel,
    input  logic [WORD_WIDTH-1:0] word_data,
    input  logic                  word_we,
    input  logic                  fill_we,
    input  logic [LINE_WIDTH-1:0] fill_line,
    output logic [WORD_WIDTH-1:0] rd_word,
    output logic [LINE_WIDTH-1:0] cur_line
);

    logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] lines [SETS];

    // Whole line fill takes priority over a word write
    always_ff @(posedge clk) begin
        if (fill_we)
            lines[index] <= fill_line;
        else if (word_we)
            lines[index][word_sel] <= word_data;
    end

    assign cur_line = lines[index];
    assign rd_word  = lines[index][word_sel];

endmodule

`default_nettype wire

//--- logic/line_memory.sv
`timescale 1ns/1ns
`default_nettype none

module line_memory
    import cache_pkg::*;
#(
    parameter int ADDR_WIDTH  = 16,
    parameter int WORD_WIDTH  = 32,
    parameter int LINE_WORDS  = 4,
    parameter int MEM_LATENCY = 6,
    localparam int WORD_BYTES  = WORD_WIDTH / 8,
    localparam int LINE_BYTES  = LINE_WORDS * WORD_BYTES,
    localparam int OFFSET_BITS = $clog2(LINE_BYTES),
    localparam int LINES       = 1 << (ADDR_WIDTH - OFFSET_BITS),
    localparam int LINE_WIDTH  = LINE_WORDS * WORD_WIDTH,
    localparam int CNT_W       = $clog2(MEM_LATENCY + 1)
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_op_t               mem_op,
    input  logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic [LINE_WIDTH-1:0] mem_wr_line,
    output logic [LINE_WIDTH-1:0] mem_rd_line,
    output logic                  mem_done
);

    localparam logic [31:0] INIT_XOR = 32'h5A5A0000;

    logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] mem_array [LINES];
    logic [CNT_W-1:0] cnt;
    logic             fire;   // Last cycle of the access

    // Each word starts as its own byte address XOR'd with a constant
    initial begin
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                mem_array[l][w] = WORD_WIDTH'(l * LINE_BYTES + w * WORD_BYTES)
                                ^ WORD_WIDTH'(INIT_XOR);
            end
        end
    end

    assign fire = !mem_done && (mem_op != op_none) && (cnt == CNT_W'(MEM_LATENCY - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= fire;
            if (fire || mem_done || mem_op == op_none)
                cnt <= '0;   // Hold idle until the next op
            else
                cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            if (mem_op == op_write)
                mem_array[mem_addr[ADDR_WIDTH-1:OFFSET_BITS]] <= mem_wr_line;
            else
                mem_rd_line <= mem_array[mem_addr[ADDR_WIDTH-1:OFFSET_BITS]];
        end
    end

    a_op_steady: assert property (@(posedge clk) disable iff (!rst_n)
        (cnt != '0) |-> $stable(mem_op));

endmodule

`default_nettype wire

//--- logic/cache_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int ADDR_WIDTH = 16,
    parameter int WORD_WIDTH = 32,
    parameter int LINE_WORDS = 4,
    parameter int INDEX_BITS = 4,
    localparam int BYTE_BITS   = $clog2(WORD_WIDTH / 8),
    localparam int SEL_BITS    = $clog2(LINE_WORDS),
    localparam int OFFSET_BITS = BYTE_BITS + SEL_BITS,
    localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS,
    localparam int LINE_WIDTH  = LINE_WORDS * WORD_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_req,
    input  logic                  wr_req,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [WORD_WIDTH-1:0] wr_data,
    input  logic                  tag_hit,
    input  logic                  tag_valid,
    input  logic                  tag_dirty,
    input  logic [TAG_BITS-1:0]   old_tag,
    input  logic [WORD_WIDTH-1:0] rd_word,
    input  logic [LINE_WIDTH-1:0] cur_line,
    input  logic                  mem_done,
    output logic [INDEX_BITS-1:0] index,
    output logic [TAG_BITS-1:0]   tag,
    output logic [SEL_BITS-1:0]   word_sel,
    output logic [WORD_WIDTH-1:0] word_data,
    output logic                  word_we,
    output logic                  fill_we,
    output mem_op_t               mem_op,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic [LINE_WIDTH-1:0] mem_wr_line,
    output logic [WORD_WIDTH-1:0] rd_data,
    output logic                  done,
    output logic                  hit,
    output logic                  busy
);

    ctrl_state_t state, next_state;

    logic [ADDR_WIDTH-1:0] addr_q;
    logic [WORD_WIDTH-1:0] data_q;
    logic                  missed_q;   // Set once a fill was needed
    logic                  rd_kind_q;  // Pending request is a read
    logic                  accept;

    assign accept = (state == idle) && (rd_req || wr_req);

    // Request payload, captured only on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr;
            data_q <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= idle;
            missed_q <= 1'b0;
        end else begin
            state <= next_state;
            if (accept)
                missed_q <= 1'b0;
            else if (state == mem_rd)
                missed_q <= 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (rd_req)
                    next_state = cmp_rd;   // Read wins if both strobes are high
                else if (wr_req)
                    next_state = cmp_wr;
            end
            cmp_rd, cmp_wr: begin
                if (tag_hit)
                    next_state = idle;
                else if (tag_valid && tag_dirty)
                    next_state = mem_wb;
                else
                    next_state = mem_rd;
            end
            mem_wb: if (mem_done) next_state = mem_rd;
            mem_rd: begin
                if (mem_done)
                    next_state = rd_kind_q ? cmp_rd : cache_wr;
            end
            cache_wr: next_state = idle;
            default:  next_state = idle;
        endcase
    end

    // Read or write kind of the pending request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rd_kind_q <= 1'b0;
        else if (accept)
            rd_kind_q <= rd_req;
    end

    // Memory op is registered so it drops for a cycle between write-back and fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_op <= op_none;
        end else if (mem_done) begin
            mem_op <= op_none;
        end else begin
            case (next_state)
                mem_wb:  mem_op <= op_write;
                mem_rd:  mem_op <= op_read;
                default: mem_op <= op_none;
            endcase
        end
    end

    assign index     = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign tag       = addr_q[ADDR_WIDTH-1 -: TAG_BITS];
    assign word_sel  = addr_q[BYTE_BITS +: SEL_BITS];
    assign word_data = data_q;

    // Evicted line goes back to its own address
    assign mem_addr    = (state == mem_wb) ? {old_tag, index, {OFFSET_BITS{1'b0}}}
                                           : {tag, index, {OFFSET_BITS{1'b0}}};
    assign mem_wr_line = cur_line;

    assign word_we = ((state == cmp_wr) && tag_hit) || (state == cache_wr);
    assign fill_we = (state == mem_rd) && mem_done;

    assign done    = (((state == cmp_rd) || (state == cmp_wr)) && tag_hit)
                   || (state == cache_wr);
    assign hit     = done && !missed_q;
    assign busy    = (state != idle);
    assign rd_data = (state == cmp_rd) ? rd_word : '0;

    a_mem_op_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_op != op_none && !mem_done) |=> $stable(mem_op));

    a_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(word_we && fill_we));

    a_no_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == idle) |-> !done);

endmodule

`default_nettype wire

//--- logic/cache_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module cache_subsystem
    import cache_pkg::*;
#(
    parameter int ADDR_WIDTH  = 16,
    parameter int WORD_WIDTH  = 32,
    parameter int LINE_WORDS  = 4,
    parameter int INDEX_BITS  = 4,
    parameter int MEM_LATENCY = 6
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rd_req,
    input  logic                  wr_req,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [WORD_WIDTH-1:0] wr_data,
    output logic [WORD_WIDTH-1:0] rd_data,
    output logic                  done,
    output logic                  hit,
    output logic                  busy
);

    localparam int SEL_BITS    = $clog2(LINE_WORDS);
    localparam int OFFSET_BITS = $clog2(WORD_WIDTH / 8) + SEL_BITS;
    localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int LINE_WIDTH  = LINE_WORDS * WORD_WIDTH;

    logic                  tag_hit, tag_valid, tag_dirty;
    logic [TAG_BITS-1:0]   old_tag, tag;
    logic [INDEX_BITS-1:0] index;
    logic [SEL_BITS-1:0]   word_sel;
    logic [WORD_WIDTH-1:0] word_data, rd_word;
    logic                  word_we, fill_we;
    logic [LINE_WIDTH-1:0] cur_line, mem_wr_line, mem_rd_line;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  mem_done;
    mem_op_t               mem_op;

    cache_ctrl #(
        .ADDR_WIDTH(ADDR_WIDTH), .WORD_WIDTH(WORD_WIDTH),
        .LINE_WORDS(LINE_WORDS), .INDEX_BITS(INDEX_BITS)
    ) i_cache_ctrl (
        .clk, .rst_n, .rd_req, .wr_req, .addr, .wr_data,
        .tag_hit, .tag_valid, .tag_dirty, .old_tag, .rd_word, .cur_line, .mem_done,
        .index, .tag, .word_sel, .word_data, .word_we, .fill_we,
        .mem_op, .mem_addr, .mem_wr_line, .rd_data, .done, .hit, .busy
    );

    cache_tag_store #(
        .ADDR_WIDTH(ADDR_WIDTH), .WORD_WIDTH(WORD_WIDTH),
        .LINE_WORDS(LINE_WORDS), .INDEX_BITS(INDEX_BITS)
    ) i_cache_tag_store (
        .clk, .rst_n, .index, .tag, .word_we, .fill_we,
        .tag_hit, .tag_valid, .tag_dirty, .old_tag
    );

    // Fill data comes straight from the memory read port
    cache_line_store #(
        .WORD_WIDTH(WORD_WIDTH), .LINE_WORDS(LINE_WORDS), .INDEX_BITS(INDEX_BITS)
    ) i_cache_line_store (
        .clk, .index, .word_sel, .word_data, .word_we, .fill_we,
        .fill_line(mem_rd_line), .rd_word, .cur_line
    );

    line_memory #(
        .ADDR_WIDTH(ADDR_WIDTH), .WORD_WIDTH(WORD_WIDTH),
        .LINE_WORDS(LINE_WORDS), .MEM_LATENCY(MEM_LATENCY)
    ) i_line_memory (
        .clk, .rst_n, .mem_op, .mem_addr, .mem_wr_line, .mem_rd_line, .mem_done
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;   // Free running

endmodule

`default_nettype wire

//--- sim/tb_cache_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_subsystem
    import cache_pkg::*;
();

    localparam int ADDR_WIDTH  = 16;
    localparam int WORD_WIDTH  = 32;
    localparam int LINE_WORDS  = 4;
    localparam int INDEX_BITS  = 4;
    localparam int MEM_LATENCY = 6;
    localparam int OFFSET_BITS = 4;   // 2 byte bits plus 2 word-select bits
    localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;
    localparam int SETS        = 1 << INDEX_BITS;

    localparam int RANDOM_REQS     = 200;
    localparam int MAX_REQS        = RANDOM_REQS + 20;
    localparam int CYCLES_PER_REQ  = 2 * (MEM_LATENCY + 2) + 4 + 4;
    localparam int WATCHDOG_CYCLES = 16 + MAX_REQS * CYCLES_PER_REQ + 200;

    logic                  clk;
    logic                  rst_n;
    logic                  rd_req;
    logic                  wr_req;
    logic [ADDR_WIDTH-1:0] addr;
    logic [WORD_WIDTH-1:0] wr_data;
    logic [WORD_WIDTH-1:0] rd_data;
    logic                  done;
    logic                  hit;
    logic                  busy;

    // Expectations for the request in flight
    logic                  exp_read;
    logic                  exp_hit;
    logic [WORD_WIDTH-1:0] exp_data;
    logic                  outstanding;

    int errors;
    int req_count;
    int done_count;

    logic [WORD_WIDTH-1:0] shadow [int];             // Written words only
    logic [SETS-1:0]       shadow_valid;
    logic [TAG_BITS-1:0]   shadow_tag [SETS];

    ctrl_state_t ctrl_state;
    assign ctrl_state = i_cache_subsystem.i_cache_ctrl.state;

    tb_clock_gen #(.PERIOD_NS(20)) i_tb_clock_gen (.clk(clk));

    cache_subsystem #(
        .ADDR_WIDTH(ADDR_WIDTH), .WORD_WIDTH(WORD_WIDTH), .LINE_WORDS(LINE_WORDS),
        .INDEX_BITS(INDEX_BITS), .MEM_LATENCY(MEM_LATENCY)
    ) i_cache_subsystem (
        .clk, .rst_n, .rd_req, .wr_req, .addr, .wr_data,
        .rd_data, .done, .hit, .busy
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory pattern unless the word was written since
    function automatic logic [WORD_WIDTH-1:0] expected_word(input logic [ADDR_WIDTH-1:0] a);
        int key;
        key = int'(a[ADDR_WIDTH-1:2]);
        if (shadow.exists(key))
            return shadow[key];
        return {16'h0000, a[ADDR_WIDTH-1:2], 2'b00} ^ 32'h5A5A0000;
    endfunction

    task automatic wait_done();
        do @(negedge clk); while (!done);
        @(posedge clk);
        outstanding <= 1'b0;
    endtask

    // One request, then optional strobes while the cache is still busy
    task automatic issue_request(input logic is_write, input logic [ADDR_WIDTH-1:0] a,
                                 input logic [WORD_WIDTH-1:0] d, input int noise);
        logic [INDEX_BITS-1:0] idx;
        logic [TAG_BITS-1:0]   tg;
        idx = a[OFFSET_BITS +: INDEX_BITS];
        tg  = a[ADDR_WIDTH-1 -: TAG_BITS];
        @(posedge clk);
        rd_req      <= !is_write;
        wr_req      <= is_write;
        addr        <= a;
        wr_data     <= d;
        exp_read    <= !is_write;
        exp_hit     <= shadow_valid[idx] && (shadow_tag[idx] == tg);
        exp_data    <= expected_word(a);
        outstanding <= 1'b1;
        if (is_write)
            shadow[int'(a[ADDR_WIDTH-1:2])] = d;
        shadow_valid[idx] = 1'b1;
        shadow_tag[idx]   = tg;
        req_count++;
        @(posedge clk);
        rd_req <= 1'b0;
        wr_req <= 1'b0;
        for (int i = 0; i < noise; i++) begin
            rd_req  <= 1'b1;
            wr_req  <= 1'b1;
            addr    <= a ^ 16'h0810;
            wr_data <= ~d;
            @(posedge clk);
            rd_req <= 1'b0;
            wr_req <= 1'b0;
        end
        wait_done();
    endtask

    always @(negedge clk) begin
        if (done)
            done_count <= done_count + 1;
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (!busy && !done && !hit))
        else begin
            errors++;
            $display("Outputs busy, done or hit were not low during reset");
        end

    a_rd_data: assert property (@(posedge clk) disable iff (!rst_n)
        (done && exp_read) |-> (rd_data == exp_data))
        else begin
            errors++;
            $display("FAILED rd_data actual %h expected %h", $sampled(rd_data),
                     $sampled(exp_data));
        end

    a_hit_flag: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (hit == exp_hit))
        else begin
            errors++;
            $display("FAILED hit actual %h expected %h", $sampled(hit), $sampled(exp_hit));
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ((rd_req || wr_req) && !busy && exp_hit) |=> (done && busy))
        else begin
            errors++;
            $display("A hitting request did not finish one cycle after its strobe");
        end

    a_miss_latency: assert property (@(posedge clk) disable iff (!rst_n)
        ((rd_req || wr_req) && !busy && !exp_hit) |=> (busy && !done))
        else begin
            errors++;
            $display("A missing request finished without a memory access");
        end

    a_done_expected: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> outstanding)
        else begin
            errors++;
            $display("done pulsed with no accepted request outstanding");
        end

    // Write-back is always followed by the fill
    a_wb_then_fill: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl_state == mem_wb) |=> (ctrl_state == mem_wb || ctrl_state == mem_rd))
        else begin
            errors++;
            $display("Controller left the write-back state for something other than the fill");
        end

    a_wr_then_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl_state == cache_wr) |=> (ctrl_state == idle))
        else begin
            errors++;
            $display("Controller did not return to idle after the word write");
        end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a request never completed",
                 WATCHDOG_CYCLES);
        $display("Requests %0d, done pulses %0d, errors %0d", req_count, done_count, errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [31:0]           seed;
        logic [ADDR_WIDTH-1:0] r_addr;
        logic                  r_write;
        rst_n        = 1'b0;
        rd_req       = 1'b0;
        wr_req       = 1'b0;
        addr         = '0;
        wr_data      = '0;
        exp_read     = 1'b0;
        exp_hit      = 1'b0;
        exp_data     = '0;
        outstanding  = 1'b0;
        errors       = 0;
        req_count    = 0;
        done_count   = 0;
        shadow_valid = '0;
        seed         = 32'h80c4538e;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        issue_request(1'b0, 16'h0120, '0, 0);            // Cold miss
        issue_request(1'b0, 16'h0120, '0, 0);            // Same word now hits
        issue_request(1'b0, 16'h0124, '0, 0);            // Other word, same line

        issue_request(1'b1, 16'h0128, 32'hCAFEF00D, 0);  // Write hit
        issue_request(1'b0, 16'h0128, '0, 0);
        issue_request(1'b1, 16'h0230, 32'h13572468, 0);  // Write miss, allocates
        issue_request(1'b0, 16'h0230, '0, 0);

        // Dirty line at index 4 evicted by a conflicting tag
        issue_request(1'b1, 16'h0340, 32'hA5A50F0F, 0);
        issue_request(1'b0, 16'h0740, '0, 0);
        issue_request(1'b0, 16'h0340, '0, 0);

        issue_request(1'b0, 16'h0550, '0, 3);            // Strobes ignored while busy
        issue_request(1'b0, 16'h0554, '0, 0);

        // Small window of tags and sets so lines keep colliding
        for (int n = 0; n < RANDOM_REQS; n++) begin
            seed    = lcg_next(seed);
            r_addr  = {6'd0, seed[21:20], 2'd0, seed[25:24], seed[27:26], 2'd0};
            r_write = seed[31];
            seed    = lcg_next(seed);
            issue_request(r_write, r_addr, seed, 0);
        end

        repeat (4) @(posedge clk);
        assert (done_count == req_count)
            else begin
                errors++;
                $display("Number of done pulses does not match the accepted requests");
            end
        $display("Requests %0d, done pulses %0d, errors %0d", req_count, done_count, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_subsystem.f
logic/cache_pkg.sv
logic/cache_tag_store.sv
logic/cache_line_store.sv
logic/line_memory.sv
logic/cache_ctrl.sv
logic/cache_subsystem.sv
sim/tb_clock_gen.sv
sim/tb_cache_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f cache_subsystem.f \
    --top-module tb_cache_subsystem -o sim_cache \
    && ./obj_dir/sim_cache > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || exit 1
exit 0
